// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_any1_decode
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/any1_decode_ctrl.sv ====
// ANY1 decode control
`default_nettype none

module any1_decode_ctrl (
	input  any1_pkg::insn_t      ir,
	output any1_pkg::decode_ctrl_t ctrl
);
	import any1_pkg::*;

	// Common settings for an instruction that writes the register named by Rt
	function automatic decode_ctrl_t reg_write(decode_ctrl_t c, imm_kind_t kind);
		decode_ctrl_t r;
		r          = c;
		r.ui       = 1'b0;
		r.rfwr     = 1'b1;
		r.rt_sel   = rt_field;
		r.imm_kind = kind;
		return r;
	endfunction

	// ============================================================
	// Opcode and function classification
	// ============================================================
	always_comb begin
		ctrl          = '0;
		ctrl.ui       = 1'b1;
		ctrl.imm_kind = imm_none;
		ctrl.rt_sel   = rt_none;
		case (ir.r.opcode)
			op_brk, op_nop: ctrl.ui = 1'b0;
			op_r1: begin
				case (ir.r.func)
					fn_abs, fn_not: ctrl = reg_write(ctrl, imm_none);
					default: ;
				endcase
			end
			op_r2: begin
				case (ir.r.func)
					fn_add, fn_sub, fn_and, fn_or, fn_xor,
					fn_mul, fn_div, fn_slt, fn_cmp: ctrl = reg_write(ctrl, imm_none);
					default: ;
				endcase
			end
			op_r3: begin
				// CHK reads a third operand and writes nothing back
				if (ir.r.func == fn_chk) begin
					ctrl.ui      = 1'b0;
					ctrl.need_rc = 1'b1;
				end
			end
			op_sys: begin
				if (ir.r.func == fn_pfi)
					ctrl.ui = 1'b0;
			end
			op_addi, op_slti: ctrl = reg_write(ctrl, imm_sext12);
			op_andi: ctrl = reg_write(ctrl, imm_ones12);
			op_ori, op_xori, op_mului, op_sltui: ctrl = reg_write(ctrl, imm_zext12);
			op_jal: begin
				ctrl            = reg_write(ctrl, imm_jal);
				ctrl.rt_sel     = rt_link;
				ctrl.stream_inc = 1'b1;
			end
			op_jalr: begin
				ctrl        = reg_write(ctrl, imm_jalr);
				ctrl.rt_sel = rt_link;
			end
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
				ctrl.ui       = 1'b0;
				ctrl.branch   = 1'b1;
				ctrl.imm_kind = imm_branch;
			end
			op_ldx: ctrl = reg_write(ctrl, imm_load);
			op_stx: begin
				// The store data register rides in the Rt slot
				ctrl.ui       = 1'b0;
				ctrl.need_rc  = 1'b1;
				ctrl.imm_kind = imm_store;
			end
			default: ;
		endcase
	end

	// ============================================================
	// Consistency of the control record
	// ============================================================
	always_comb begin
		assert (!(ctrl.ui && (ctrl.rfwr || ctrl.need_rc || ctrl.branch)))
			else $error("unimplemented instruction carries an action flag");
		assert (!(ctrl.branch && ctrl.rfwr))
			else $error("branch requests a register write");
	end

endmodule

`default_nettype wire

// ==== hw/any1_decode_reg.sv ====
// ANY1 decode output register
`default_nettype none

module any1_decode_reg (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            in_valid,
	input  any1_pkg::fetch_t                fetch,
	input  any1_pkg::decode_ctrl_t          ctrl,
	input  logic [any1_pkg::word_width-1:0] imm,
	input  any1_pkg::regs_t                 regs,
	output logic                            out_valid,
	output any1_pkg::decoded_t              dec
);
	import any1_pkg::*;

	decoded_t dec_next;

	// ============================================================
	// Record assembly
	// ============================================================
	always_comb begin
		dec_next.ir            = fetch.ir;
		dec_next.ip            = fetch.ip;
		dec_next.pip           = fetch.pip;
		dec_next.predict_taken = fetch.predict_taken;
		dec_next.regs          = regs;
		dec_next.imm           = imm;
		dec_next.ui            = ctrl.ui;
		dec_next.rfwr          = ctrl.rfwr;
		dec_next.need_rc       = ctrl.need_rc;
		dec_next.branch        = ctrl.branch;
		dec_next.stream_inc    = ctrl.stream_inc;
	end

	// The record holds until the next accepted strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			dec       <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid)
				dec <= dec_next;
		end
	end

	// Each output pulse is owed to the strobe in the cycle before it
	a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid))
		else $error("out_valid without a strobe in the previous cycle");

endmodule

`default_nettype wire

// ==== hw/any1_decode_stage.sv ====
// ANY1 decode stage
`default_nettype none

module any1_decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  any1_pkg::fetch_t   fetch,
	output logic               out_valid,
	output any1_pkg::decoded_t dec
);
	import any1_pkg::*;

	decode_ctrl_t          ctrl;
	regs_t                 regs;
	logic [word_width-1:0] imm;

	any1_decode_ctrl u_ctrl (
		.ir   (fetch.ir),
		.ctrl (ctrl)
	);

	any1_imm_gen u_imm (
		.ir       (fetch.ir),
		.imm_kind (ctrl.imm_kind),
		.imm      (imm)
	);

	any1_reg_select u_regs (
		.ir      (fetch.ir),
		.rt_sel  (ctrl.rt_sel),
		.need_rc (ctrl.need_rc),
		.regs    (regs)
	);

	// Single pipeline register between fetch and the issue side
	any1_decode_reg u_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.fetch     (fetch),
		.ctrl      (ctrl),
		.imm       (imm),
		.regs      (regs),
		.out_valid (out_valid),
		.dec       (dec)
	);

endmodule

`default_nettype wire

// ==== hw/any1_imm_gen.sv ====
// ANY1 immediate generator
`default_nettype none

module any1_imm_gen (
	input  any1_pkg::insn_t                   ir,
	input  any1_pkg::imm_kind_t               imm_kind,
	output logic [any1_pkg::word_width-1:0] imm
);
	import any1_pkg::*;

	logic [insn_width-1:0] w;
	logic [11:0]           imm12;
	logic [word_width-1:0] sext12;
	logic [word_width-1:0] ones12;
	logic [word_width-1:0] zext12;
	logic [word_width-1:0] jal_imm;
	logic [word_width-1:0] jalr_imm;
	logic [word_width-1:0] br_imm;
	logic [word_width-1:0] ld_imm;
	logic [word_width-1:0] st_imm;

	assign w     = ir;
	assign imm12 = w[31:20];

	// ============================================================
	// Candidate formats
	// ============================================================
	assign sext12 = {{52{imm12[11]}}, imm12};
	assign ones12 = {{52{1'b1}}, imm12};
	assign zext12 = {52'd0, imm12};

	// Jump targets are word aligned, so the low two bits are implied
	assign jal_imm  = {{40{w[31]}}, w[31:10], 2'b00};
	assign jalr_imm = {{50{imm12[11]}}, imm12, 2'b00};

	// Branch displacement is split by the Rt slot, which holds the low half
	assign br_imm = {{50{ir.r.func[5]}}, ir.r.func, ir.r.rt, 2'b00};

	assign ld_imm = {{56{ir.ld.disp[7]}}, ir.ld.disp};
	assign st_imm = {{56{ir.st.disphi[1]}}, ir.st.disphi, ir.st.displo};

	// ============================================================
	// Format select
	// ============================================================
	always_comb begin
		case (imm_kind)
			imm_sext12: imm = sext12;
			imm_ones12: imm = ones12;
			imm_zext12: imm = zext12;
			imm_jal:    imm = jal_imm;
			imm_jalr:   imm = jalr_imm;
			imm_branch: imm = br_imm;
			imm_load:   imm = ld_imm;
			imm_store:  imm = st_imm;
			default:    imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/any1_pkg.sv ====
// ANY1 decode definitions
`default_nettype none

package any1_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int insn_width = 32;
	localparam int addr_width = 32;
	localparam int word_width = 64;
	localparam int reg_width  = 6;

	typedef logic [addr_width-1:0] address_t;
	typedef logic [reg_width-1:0]  regno_t;

	// ============================================================
	// Opcode and function codes
	// ============================================================
	// The branch group sits at 0x48 to 0x4D
	typedef enum logic [7:0] {
		op_brk   = 8'h00,
		op_r1    = 8'h01,
		op_r2    = 8'h02,
		op_r3    = 8'h03,
		op_addi  = 8'h04,
		op_sys   = 8'h07,
		op_andi  = 8'h08,
		op_ori   = 8'h09,
		op_xori  = 8'h0A,
		op_mului = 8'h0E,
		op_slti  = 8'h14,
		op_sltui = 8'h15,
		op_nop   = 8'h3F,
		op_jal   = 8'h40,
		op_jalr  = 8'h41,
		op_beq   = 8'h48,
		op_bne   = 8'h49,
		op_blt   = 8'h4A,
		op_bge   = 8'h4B,
		op_bltu  = 8'h4C,
		op_bgeu  = 8'h4D,
		op_ldx   = 8'h60,
		op_stx   = 8'h70
	} opcode_t;

	// Function codes are shared by the R1, R2, R3 and SYS groups
	typedef enum logic [5:0] {
		fn_abs = 6'h01,
		fn_not = 6'h02,
		fn_add = 6'h04,
		fn_sub = 6'h05,
		fn_and = 6'h08,
		fn_or  = 6'h09,
		fn_xor = 6'h0A,
		fn_mul = 6'h0C,
		fn_div = 6'h10,
		fn_slt = 6'h14,
		fn_cmp = 6'h18,
		fn_chk = 6'h20,
		fn_pfi = 6'h30
	} func_t;

	// ============================================================
	// Instruction word views
	// ============================================================
	typedef struct packed {
		func_t   func;
		regno_t  rb;
		regno_t  ra;
		regno_t  rt;
		opcode_t opcode;
	} insn_reg_t;

	typedef struct packed {
		logic [7:0] disp;
		logic [3:0] size;
		regno_t     ra;
		regno_t     rt;
		opcode_t    opcode;
	} insn_ld_t;

	// Store data register takes the Rt slot and the displacement is split around it
	typedef struct packed {
		logic [1:0] disphi;
		logic [3:0] size;
		logic [5:0] displo;
		regno_t     ra;
		regno_t     rc;
		opcode_t    opcode;
	} insn_st_t;

	typedef union packed {
		insn_reg_t r;
		insn_ld_t  ld;
		insn_st_t  st;
	} insn_t;

	// ============================================================
	// Decode records
	// ============================================================
	typedef enum logic [3:0] {
		imm_none,
		imm_sext12,
		imm_ones12,
		imm_zext12,
		imm_jal,
		imm_jalr,
		imm_branch,
		imm_load,
		imm_store
	} imm_kind_t;

	typedef enum logic [1:0] {
		rt_none,
		rt_field,
		rt_link
	} rt_sel_t;

	typedef struct packed {
		insn_t    ir;
		address_t ip;
		address_t pip;
		logic     predict_taken;
	} fetch_t;

	typedef struct packed {
		logic      ui;
		logic      rfwr;
		logic      need_rc;
		logic      branch;
		logic      stream_inc;
		imm_kind_t imm_kind;
		rt_sel_t   rt_sel;
	} decode_ctrl_t;

	typedef struct packed {
		regno_t ra;
		regno_t rb;
		regno_t rc;
		regno_t rt;
	} regs_t;

	typedef struct packed {
		insn_t                 ir;
		address_t              ip;
		address_t              pip;
		logic                  predict_taken;
		regs_t                 regs;
		logic [word_width-1:0] imm;
		logic                  ui;
		logic                  rfwr;
		logic                  need_rc;
		logic                  branch;
		logic                  stream_inc;
	} decoded_t;

endpackage

`default_nettype wire

// ==== hw/any1_reg_select.sv ====
// ANY1 register number select
`default_nettype none

module any1_reg_select (
	input  any1_pkg::insn_t   ir,
	input  any1_pkg::rt_sel_t rt_sel,
	input  logic              need_rc,
	output any1_pkg::regs_t   regs
);
	import any1_pkg::*;

	regno_t link_rt;

	// Link registers are limited to the first four
	assign link_rt = {{(reg_width-2){1'b0}}, ir.r.rt[1:0]};

	// Source operands are always read from the register form
	assign regs.ra = ir.r.ra;
	assign regs.rb = ir.r.rb;

	// Third source shares the Rt slot, which the store view names Rc
	assign regs.rc = need_rc ? ir.st.rc : '0;

	always_comb begin
		case (rt_sel)
			rt_field: regs.rt = ir.r.rt;
			rt_link:  regs.rt = link_rt;
			default:  regs.rt = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== sim/any1_decode_stim.txt ====
// First value is the record count, then one instruction per line
// insn ip pip predict_taken gap ra rb rc rt imm flags(ui rfwr need_rc branch stream_inc)
15
10308102 00001000 00001004 0 0 02 03 00 01 0000000000000000 08
04014601 00001004 00001008 0 1 05 00 00 06 0000000000000000 08
FFC1C804 00001008 0000100C 0 0 07 3C 00 08 FFFFFFFFFFFFFFFC 08
0F004208 0000100C 00001010 0 2 01 30 00 02 FFFFFFFFFFFFF0F0 08
8000C409 00001010 00001014 0 0 03 00 00 04 0000000000000800 08
80124A14 00001014 00001018 0 1 09 01 00 0A FFFFFFFFFFFFF801 08
FFFFFF0E 00001018 0000101C 0 0 3F 3F 00 3F 0000000000000FFF 08
00123740 0000101C 00002250 1 3 08 01 00 03 0000000000001234 09
FFFFF940 00002250 00002248 1 0 3F 3F 00 01 FFFFFFFFFFFFFFF8 09
01010641 00002248 00002800 0 1 04 10 00 02 0000000000000040 08
FC207E48 00002800 000027F8 1 0 01 02 00 00 FFFFFFFFFFFFFFF8 02
0440C54D 000027F8 000027FC 0 2 03 04 00 00 0000000000000114 02
80308760 000027FC 00002800 0 0 02 03 00 07 FFFFFFFFFFFFFF80 08
8D514970 00002800 00002804 0 1 05 15 09 00 FFFFFFFFFFFFFF95 04
80108B03 00002804 00002808 0 0 02 01 0B 00 0000000000000000 04
123456FF 00002808 0000280C 0 3 11 23 00 00 0000000000000000 10
FC104102 0000280C 00002810 0 0 01 01 00 00 0000000000000000 10
04000007 00002810 00002814 0 0 00 00 00 00 0000000000000000 10
00C04300 00002814 00002818 0 1 01 0C 00 00 0000000000000000 00
0000003F 00002818 0000281C 0 0 00 00 00 00 0000000000000000 00
C0000007 0000281C 00002820 0 0 00 00 00 00 0000000000000000 00

// ==== include/any1_decode_checks.svh ====
// ANY1 decode compare tasks
`ifndef ANY1_DECODE_CHECKS_SVH
`define ANY1_DECODE_CHECKS_SVH

// Flag order is ui, rfwr, need_rc, branch, stream_inc
function automatic logic [4:0] flags_of(any1_pkg::decoded_t d);
	return {d.ui, d.rfwr, d.need_rc, d.branch, d.stream_inc};
endfunction

task automatic check_regs(input string name, input any1_pkg::regs_t got,
		input any1_pkg::regs_t exp, output bit ok);
	ok = (got === exp);
	if (!ok)
		$display("[FAIL] %0t %s regs ra=%0d rb=%0d rc=%0d rt=%0d, expected %0d %0d %0d %0d",
			$time, name, got.ra, got.rb, got.rc, got.rt, exp.ra, exp.rb, exp.rc, exp.rt);
	else
		$display("[PASS] %s regs", name);
endtask

task automatic check_imm(input string name, input logic [any1_pkg::word_width-1:0] got,
		input logic [any1_pkg::word_width-1:0] exp, output bit ok);
	ok = (got === exp);
	if (!ok)
		$display("[FAIL] %0t %s imm %h, expected %h", $time, name, got, exp);
	else
		$display("[PASS] %s imm", name);
endtask

task automatic check_flags(input string name, input any1_pkg::decoded_t got,
		input logic [4:0] exp, output bit ok);
	logic [4:0] f;
	f  = flags_of(got);
	ok = (f === exp);
	if (!ok)
		$display("[FAIL] %0t %s flags %b, expected %b", $time, name, f, exp);
	else
		$display("[PASS] %s flags", name);
endtask

`endif

// ==== sim/tb_any1_decode.sv ====
// ANY1 decode stage testbench
`default_nettype none

module tb_any1_decode;
	timeunit 1ns;
	timeprecision 1ps;
	import any1_pkg::*;

	localparam int fields      = 11;
	localparam int max_records = 64;
	localparam int clk_period  = 40;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	fetch_t   fetch;
	logic     out_valid;
	decoded_t dec;

	logic [63:0] stim [0:fields*max_records];
	int          n_records;
	int          max_gap;
	int          n_pass;
	int          n_fail;
	int          seed;

	`include "any1_decode_checks.svh"

	any1_decode_stage uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.fetch     (fetch),
		.out_valid (out_valid),
		.dec       (dec)
	);

	always #(clk_period/2) clk = ~clk;

	task automatic expect_valid(input string name, input logic got, input logic exp,
			output bit ok);
		ok = (got === exp);
		if (!ok)
			$display("[FAIL] %0t %s out_valid %b, expected %b", $time, name, got, exp);
	endtask

	// Fetch fields must reach the record untouched
	task automatic verify_passthrough(input string name, input fetch_t sent,
			input decoded_t got, output bit ok);
		ok = (got.ir === sent.ir) && (got.ip === sent.ip) && (got.pip === sent.pip)
			&& (got.predict_taken === sent.predict_taken);
		if (!ok)
			$display("[FAIL] %0t %s fetch ir=%h ip=%h pip=%h pt=%b, expected %h %h %h %b",
				$time, name, got.ir, got.ip, got.pip, got.predict_taken,
				sent.ir, sent.ip, sent.pip, sent.predict_taken);
		else
			$display("[PASS] %s fetch fields", name);
	endtask

	// ============================================================
	// Record playback, one instruction per stimulus line
	// ============================================================
	task automatic run_records();
		string                 name;
		fetch_t                sent;
		regs_t                 exp_regs;
		logic [word_width-1:0] exp_imm;
		logic [4:0]            exp_flags;
		int                    gap;
		int                    base;
		bit                    ok;
		bit                    all_ok;
		for (int i = 0; i < n_records; i++) begin
			base               = 1 + i * fields;
			sent.ir            = stim[base][31:0];
			sent.ip            = stim[base+1][31:0];
			sent.pip           = stim[base+2][31:0];
			sent.predict_taken = stim[base+3][0];
			gap                = int'(stim[base+4]);
			exp_regs.ra        = stim[base+5][5:0];
			exp_regs.rb        = stim[base+6][5:0];
			exp_regs.rc        = stim[base+7][5:0];
			exp_regs.rt        = stim[base+8][5:0];
			exp_imm            = stim[base+9];
			exp_flags          = stim[base+10][4:0];
			name               = $sformatf("test %0d", i + 1);
			fetch    = sent;
			in_valid = 1'b1;
			@(negedge clk);
			in_valid = 1'b0;
			all_ok   = 1'b1;
			expect_valid(name, out_valid, 1'b1, ok);
			all_ok &= ok;
			check_regs(name, dec.regs, exp_regs, ok);
			all_ok &= ok;
			check_imm(name, dec.imm, exp_imm, ok);
			all_ok &= ok;
			check_flags(name, dec, exp_flags, ok);
			all_ok &= ok;
			verify_passthrough(name, sent, dec, ok);
			all_ok &= ok;
			// Junk on the fetch bus while idle must not reach the record
			repeat (gap) begin
				fetch = {$random(seed), $random(seed), $random(seed), 1'b1};
				@(negedge clk);
				expect_valid(name, out_valid, 1'b0, ok);
				all_ok &= ok;
				if (dec.ip !== sent.ip || dec.ir !== sent.ir) begin
					$display("[FAIL] %0t %s record changed while in_valid was low", $time, name);
					all_ok = 1'b0;
				end
			end
			if (all_ok)
				n_pass++;
			else
				n_fail++;
			$display("%s finished %s", name, all_ok ? "clean" : "with mismatches");
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		bit ok;
		clk      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		fetch    = '0;
		seed     = 74;
		n_pass   = 0;
		n_fail   = 0;
		max_gap  = 0;
		$readmemh("sim/any1_decode_stim.txt", stim);
		n_records = int'(stim[0]);
		if (n_records > max_records)
			n_records = 0;
		for (int i = 0; i < n_records; i++)
			if (int'(stim[1 + i * fields + 4]) > max_gap)
				max_gap = int'(stim[1 + i * fields + 4]);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		expect_valid("reset", out_valid, 1'b0, ok);
		if (dec !== '0) begin
			$display("[FAIL] %0t reset record is not all zero", $time);
			ok = 1'b0;
		end
		if (ok)
			n_pass++;
		else
			n_fail++;
		$display("reset test finished %s", ok ? "clean" : "with mismatches");
		if (n_records < 1) begin
			$display("The stimulus file holds no usable records");
			n_fail++;
		end else begin
			run_records();
		end
		$display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Allows every record its gap plus a few cycles of latency
	initial begin
		int limit_ns;
		wait (rst_n === 1'b1);
		limit_ns = (n_records * (max_gap + 4) + 4) * clk_period;
		#limit_ns;
		$display("Timeout: the decode run did not finish within %0d ns", limit_ns);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hw/any1_pkg.sv
hw/any1_decode_ctrl.sv
hw/any1_imm_gen.sv
hw/any1_reg_select.sv
hw/any1_decode_reg.sv
hw/any1_decode_stage.sv
sim/tb_any1_decode.sv
